// ==== soc_interconnect_pkg.sv ====
// The address map is fixed at elaboration and every slave must present read data in the cycle after its gnt
package soc_interconnect_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Port counts
    ////////////////////////////////////////////////////////////////////////////

    // Masters that can reach every region of the map
    localparam int unsigned NUM_MASTERS = 2;
    // Word-interleaved SRAM banks, arbitrated ports 0 to NUM_BANKS-1
    localparam int unsigned NUM_BANKS = 4;
    // Contiguous peripheral slaves, placed right after the banks
    localparam int unsigned NUM_CONTIG = 2;
    localparam int unsigned NUM_SLAVES = NUM_BANKS + NUM_CONTIG;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned BE_W = DATA_W / 8;

    // Index widths used by the arbiters and the router
    localparam int unsigned MASTER_IDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;
    localparam int unsigned SLAVE_IDX_W = $clog2(NUM_SLAVES);

    ////////////////////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////////////////////

    // Interleaved region spans 0x1C00_0000 up to 0x1C00_FFFF
    localparam logic [ADDR_W-1:0] INTLV_BASE = 32'h1C00_0000;
    // Bits that must equal INTLV_BASE for an interleaved hit
    localparam logic [ADDR_W-1:0] INTLV_MASK = 32'hFFFF_0000;
    // Bank index sits just above the byte lane bits of the word address
    localparam int unsigned BANK_SEL_LSB = 2;
    localparam int unsigned BANK_SEL_W = $clog2(NUM_BANKS);

    // Contiguous slave n starts at CONTIG_BASE + n * CONTIG_SIZE
    localparam logic [ADDR_W-1:0] CONTIG_BASE = 32'h1A00_0000;
    localparam int unsigned CONTIG_SIZE = 32'h0000_1000;
    // Number of offset bits inside one contiguous slave
    localparam int unsigned CONTIG_OFFS_W = $clog2(CONTIG_SIZE);

    // Read data returned for addresses that hit no region
    localparam logic [DATA_W-1:0] ERROR_WORD = 32'hBADA_CCE5;

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    // Kind of target a decoded address reaches
    typedef enum logic [1:0] {
        TGT_BANK,
        TGT_CONTIG,
        TGT_ERROR
    } target_e;

    // TCDM request as driven by a master, 70 bits
    typedef struct packed {
        logic              req;
        logic [ADDR_W-1:0] addr;
        // High for a write, low for a read
        logic              we;
        logic [BE_W-1:0]   be;
        logic [DATA_W-1:0] wdata;
    } tcdm_req_t;

    // TCDM response as seen by a master, 35 bits
    typedef struct packed {
        logic              gnt;
        logic              r_valid;
        // Raised together with r_valid for an access that hit no region
        logic              r_opc;
        logic [DATA_W-1:0] r_rdata;
    } tcdm_rsp_t;

    // Arbitrated slave port index, banks first
    typedef logic [SLAVE_IDX_W-1:0] slave_sel_t;

    // One bit per master, used for hit and grant masks
    typedef logic [NUM_MASTERS-1:0] master_sel_t;

endpackage

// ==== tcdm_addr_decoder.sv ====
// Purely combinational and decodes the address even while req is low, so callers must qualify it
`timescale 1ns/10ps

module tcdm_addr_decoder (
    input  soc_interconnect_pkg::tcdm_req_t         req_i,
    output soc_interconnect_pkg::target_e           target_o,
    output soc_interconnect_pkg::slave_sel_t        slave_idx_o,
    output logic [soc_interconnect_pkg::ADDR_W-1:0] local_addr_o
);

    import soc_interconnect_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Interleaved region
    ////////////////////////////////////////////////////////////////////////////

    logic                            intlv_hit;
    logic [ADDR_W-1:0]               intlv_offs;
    logic [BANK_SEL_W-1:0]           bank_idx;
    logic [ADDR_W-1:0]               bank_addr;

    // Upper address bits must match the region base exactly
    assign intlv_hit = (req_i.addr & INTLV_MASK) == INTLV_BASE;

    // Byte offset from the start of the interleaved region
    assign intlv_offs = req_i.addr & ~INTLV_MASK;

    // Consecutive words land on consecutive banks
    assign bank_idx = intlv_offs[BANK_SEL_LSB +: BANK_SEL_W];

    // The bank bits are squeezed out of the word address
    // Byte lane bits stay in place so the bank sees a plain byte address
    assign bank_addr = {
        {BANK_SEL_W{1'b0}},
        intlv_offs[ADDR_W-1:BANK_SEL_LSB+BANK_SEL_W],
        intlv_offs[BANK_SEL_LSB-1:0]
    };

    ////////////////////////////////////////////////////////////////////////////
    // Contiguous region
    ////////////////////////////////////////////////////////////////////////////

    logic [ADDR_W-1:0]               contig_offs;
    logic [ADDR_W-CONTIG_OFFS_W-1:0] contig_sel;

    // Addresses below CONTIG_BASE wrap to a huge offset and match no slave
    assign contig_offs = req_i.addr - CONTIG_BASE;

    // Which CONTIG_SIZE window the offset falls into
    assign contig_sel = contig_offs[ADDR_W-1:CONTIG_OFFS_W];

    ////////////////////////////////////////////////////////////////////////////
    // Target selection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // Anything that misses both regions goes to the error responder
        target_o     = TGT_ERROR;
        slave_idx_o  = '0;
        local_addr_o = '0;

        if (intlv_hit) begin
            target_o     = TGT_BANK;
            slave_idx_o  = slave_sel_t'(bank_idx);
            local_addr_o = bank_addr;
        end else begin
            // Contiguous slaves follow the banks in the port numbering
            for (int n = 0; n < NUM_CONTIG; n++) begin
                if (contig_sel == (ADDR_W-CONTIG_OFFS_W)'(n)) begin
                    target_o     = TGT_CONTIG;
                    slave_idx_o  = slave_sel_t'(NUM_BANKS + n);
                    local_addr_o = {
                        {(ADDR_W-CONTIG_OFFS_W){1'b0}},
                        contig_offs[CONTIG_OFFS_W-1:0]
                    };
                end
            end
        end
    end

endmodule

// ==== tcdm_bank_arbiter.sv ====
// Grant is combinational from hit_i and slave_gnt_i, so the slave gnt must not depend on this arbiter's gnt_o
`timescale 1ns/10ps

module tcdm_bank_arbiter (
    input  logic                                     clk_i,
    input  logic                                     rst_n_i,
    input  soc_interconnect_pkg::tcdm_req_t [soc_interconnect_pkg::NUM_MASTERS-1:0] req_i,
    input  soc_interconnect_pkg::master_sel_t        hit_i,
    input  logic [soc_interconnect_pkg::NUM_MASTERS-1:0]
                 [soc_interconnect_pkg::ADDR_W-1:0]  local_addr_i,
    output soc_interconnect_pkg::tcdm_req_t          slave_req_o,
    input  logic                                     slave_gnt_i,
    output soc_interconnect_pkg::master_sel_t        gnt_o
);

    import soc_interconnect_pkg::*;

    // Master that gets first look in the next arbitration round
    logic [MASTER_IDX_W-1:0] ptr_q;
    logic [MASTER_IDX_W-1:0] ptr_next;
    // Master picked in the current cycle
    logic [MASTER_IDX_W-1:0] winner;
    logic                    any_hit;
    logic                    granted;

    ////////////////////////////////////////////////////////////////////////////
    // Round-robin selection
    ////////////////////////////////////////////////////////////////////////////

    // Only masters whose decode chose this slave take part
    assign any_hit = |hit_i;

    always_comb begin
        int   cand;
        logic found;

        winner = ptr_q;
        found  = 1'b0;
        cand   = 0;
        // Walk the masters starting at the pointer and stop at the first hit
        for (int k = 0; k < NUM_MASTERS; k++) begin
            cand = (ptr_q + k) % NUM_MASTERS;
            if (!found && hit_i[cand]) begin
                winner = MASTER_IDX_W'(cand);
                found  = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Request forwarding
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // Payload of the winner, rebased to the slave's own address space
        slave_req_o      = req_i[winner];
        slave_req_o.addr = local_addr_i[winner];
        // The slave only sees a request when some master targets it
        slave_req_o.req  = any_hit;
    end

    // A grant happens when the slave accepts the forwarded request
    assign granted = any_hit & slave_gnt_i;

    // Grant returns to exactly one master, or to none
    assign gnt_o = granted ? (master_sel_t'(1) << winner) : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Priority pointer
    ////////////////////////////////////////////////////////////////////////////

    // Priority passes to the master after the winner
    assign ptr_next = MASTER_IDX_W'((winner + 1) % NUM_MASTERS);

    // While the slave holds gnt low the order stays as it is
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else if (granted) begin
            ptr_q <= ptr_next;
        end
    end

endmodule

// ==== tcdm_response_router.sv ====
// Assumes each slave presents rdata exactly one cycle after its gnt and at most one grant per master per cycle
`timescale 1ns/10ps

module tcdm_response_router (
    input  logic                                     clk_i,
    input  logic                                     rst_n_i,
    input  soc_interconnect_pkg::target_e [soc_interconnect_pkg::NUM_MASTERS-1:0] target_i,
    input  soc_interconnect_pkg::slave_sel_t [soc_interconnect_pkg::NUM_MASTERS-1:0]
                                                     slave_idx_i,
    input  soc_interconnect_pkg::master_sel_t        req_valid_i,
    input  soc_interconnect_pkg::master_sel_t [soc_interconnect_pkg::NUM_SLAVES-1:0]
                                                     arb_gnt_i,
    input  logic [soc_interconnect_pkg::NUM_SLAVES-1:0]
                 [soc_interconnect_pkg::DATA_W-1:0]  slave_rdata_i,
    output soc_interconnect_pkg::tcdm_rsp_t [soc_interconnect_pkg::NUM_MASTERS-1:0] rsp_o
);

    import soc_interconnect_pkg::*;

    // What a granted master needs to find its data one cycle later
    typedef struct packed {
        logic       err;
        slave_sel_t idx;
    } rsp_rec_t;

    master_sel_t                err_hit;
    master_sel_t                gnt;
    master_sel_t                valid_q;
    rsp_rec_t [NUM_MASTERS-1:0] rec_d;
    rsp_rec_t [NUM_MASTERS-1:0] rec_q;

    ////////////////////////////////////////////////////////////////////////////
    // Grant collection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            // The error responder never stalls, so it grants at once
            err_hit[m] = req_valid_i[m] && (target_i[m] == TGT_ERROR);
            gnt[m]     = err_hit[m];
            // At most one arbiter can grant a given master
            for (int s = 0; s < NUM_SLAVES; s++) begin
                gnt[m] = gnt[m] | arb_gnt_i[s][m];
            end
            rec_d[m].err = err_hit[m];
            rec_d[m].idx = slave_idx_i[m];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Response records
    ////////////////////////////////////////////////////////////////////////////

    // One pending response per master, raised in the cycle after its gnt
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= gnt;
        end
    end

    // Record is only read while valid_q is high
    always_ff @(posedge clk_i) begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            if (gnt[m]) begin
                rec_q[m] <= rec_d[m];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Response drive
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            rsp_o[m].gnt     = gnt[m];
            rsp_o[m].r_valid = valid_q[m];
            rsp_o[m].r_opc   = valid_q[m] & rec_q[m].err;
            if (!valid_q[m]) begin
                rsp_o[m].r_rdata = '0;
            end else if (rec_q[m].err) begin
                rsp_o[m].r_rdata = ERROR_WORD;
            end else begin
                // Slave granted last cycle, so its rdata is valid now
                rsp_o[m].r_rdata = slave_rdata_i[rec_q[m].idx];
            end
        end
    end

endmodule

// ==== soc_interconnect.sv ====
// Slaves must raise gnt only with req and return rdata one cycle later, and the error region always grants
`timescale 1ns/10ps

module soc_interconnect (
    input  logic                                     clk_i,
    input  logic                                     rst_n_i,
    input  soc_interconnect_pkg::tcdm_req_t [soc_interconnect_pkg::NUM_MASTERS-1:0] master_req_i,
    output soc_interconnect_pkg::tcdm_rsp_t [soc_interconnect_pkg::NUM_MASTERS-1:0] master_rsp_o,
    output soc_interconnect_pkg::tcdm_req_t [soc_interconnect_pkg::NUM_SLAVES-1:0]  slave_req_o,
    input  logic [soc_interconnect_pkg::NUM_SLAVES-1:0] slave_gnt_i,
    input  logic [soc_interconnect_pkg::NUM_SLAVES-1:0]
                 [soc_interconnect_pkg::DATA_W-1:0]  slave_rdata_i
);

    import soc_interconnect_pkg::*;

    target_e     [NUM_MASTERS-1:0]             target;
    slave_sel_t  [NUM_MASTERS-1:0]             slave_idx;
    logic        [NUM_MASTERS-1:0][ADDR_W-1:0] local_addr;
    master_sel_t                               req_valid;
    master_sel_t [NUM_SLAVES-1:0]              hit;
    master_sel_t [NUM_SLAVES-1:0]              arb_gnt;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode, one decoder per master
    ////////////////////////////////////////////////////////////////////////////

    for (genvar m = 0; m < NUM_MASTERS; m++) begin : gen_decoder
        tcdm_addr_decoder decoder_i (
            .req_i        (master_req_i[m]),
            .target_o     (target[m]),
            .slave_idx_o  (slave_idx[m]),
            .local_addr_o (local_addr[m])
        );
        assign req_valid[m] = master_req_i[m].req;
    end

    // Each slave port sees the masters whose request decodes to it
    // Error-target requests reach no arbiter
    always_comb begin
        for (int s = 0; s < NUM_SLAVES; s++) begin
            for (int m = 0; m < NUM_MASTERS; m++) begin
                hit[s][m] = req_valid[m] && (target[m] != TGT_ERROR)
                            && (slave_idx[m] == slave_sel_t'(s));
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Arbitration, one arbiter per slave port
    ////////////////////////////////////////////////////////////////////////////

    for (genvar s = 0; s < NUM_SLAVES; s++) begin : gen_arbiter
        tcdm_bank_arbiter arbiter_i (
            .clk_i,
            .rst_n_i,
            .req_i        (master_req_i),
            .hit_i        (hit[s]),
            .local_addr_i (local_addr),
            .slave_req_o  (slave_req_o[s]),
            .slave_gnt_i  (slave_gnt_i[s]),
            .gnt_o        (arb_gnt[s])
        );
    end

    // Grants, error answers and read data all come back through here
    tcdm_response_router router_i (
        .clk_i,
        .rst_n_i,
        .target_i      (target),
        .slave_idx_i   (slave_idx),
        .req_valid_i   (req_valid),
        .arb_gnt_i     (arb_gnt),
        .slave_rdata_i (slave_rdata_i),
        .rsp_o         (master_rsp_o)
    );

endmodule

// ==== tb_clock_gen.sv ====
// Free-running clock that starts low at time zero, with a period fixed at 100 ns
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o
);

    // Full period in ns, so each half lasts 50 ns
    localparam int PERIOD_NS = 100;

    initial begin
        clk_o = 1'b0;
    end

    // The first rising edge falls at 50 ns
    always begin
        #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

// ==== soc_interconnect_assertions.sv ====
// Bound into the response router and into every bank arbiter, and only checked while out of reset
`timescale 1ns/10ps

module soc_interconnect_assertions #(
    parameter bit ROUTER_SIDE = 1'b0
) (
    input logic                              clk_i,
    input logic                              rst_n_i,
    input soc_interconnect_pkg::master_sel_t gnt_i,
    input soc_interconnect_pkg::master_sel_t req_i,
    input soc_interconnect_pkg::master_sel_t r_valid_i
);

    import soc_interconnect_pkg::*;

    // Failed assertions, read by the testbench for its final verdict
    int fail_count = 0;

    // A grant only ever goes to a master that asks for this target
    assert property (@(posedge clk_i) disable iff (!rst_n_i) (gnt_i & ~req_i) == '0)
        else begin
            $error("grant raised for a master without a request");
            fail_count++;
        end

    if (ROUTER_SIDE) begin : gen_router
        // r_valid rises in the cycle after each gnt and at no other time
        for (genvar m = 0; m < NUM_MASTERS; m++) begin : gen_master
            assert property (@(posedge clk_i) disable iff (!rst_n_i) gnt_i[m] |=> r_valid_i[m])
                else begin
                    $error("r_valid missing one cycle after gnt");
                    fail_count++;
                end
            assert property (@(posedge clk_i) disable iff (!rst_n_i) !gnt_i[m] |=> !r_valid_i[m])
                else begin
                    $error("r_valid raised without a gnt in the cycle before");
                    fail_count++;
                end
        end
    end else begin : gen_arbiter
        // One slave port grants at most one master per cycle
        assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(gnt_i))
            else begin
                $error("arbiter grant mask is not one-hot");
                fail_count++;
            end
    end

endmodule

bind tcdm_response_router soc_interconnect_assertions #(.ROUTER_SIDE(1'b1)) rsp_checks_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .gnt_i     (gnt),
    .req_i     (req_valid_i),
    .r_valid_i (valid_q)
);

bind tcdm_bank_arbiter soc_interconnect_assertions #(.ROUTER_SIDE(1'b0)) arb_checks_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .gnt_i     (gnt_o),
    .req_i     (hit_i),
    .r_valid_i ('0)
);

// ==== tb_soc_interconnect.sv ====
// Reads soc_interconnect_trace.txt from the run directory, lines of a group must be adjacent
`timescale 1ns/10ps

module tb_soc_interconnect;

    import soc_interconnect_pkg::*;

    localparam int MAX_LINES = 64;
    localparam int FIELDS = 8;
    localparam int GROUP_TIMEOUT = 60;
    localparam int MEM_WORDS = 256;
    localparam logic [31:0] LFSR_SEED = 32'h63f9138b;

    logic                              clk_i;
    logic                              rst_n_i;
    tcdm_req_t [NUM_MASTERS-1:0]       master_req;
    tcdm_rsp_t [NUM_MASTERS-1:0]       master_rsp;
    tcdm_req_t [NUM_SLAVES-1:0]        slave_req;
    logic [NUM_SLAVES-1:0]             slave_gnt;
    logic [NUM_SLAVES-1:0][DATA_W-1:0] slave_rdata = '0;

    logic [31:0] trace_mem [MAX_LINES*FIELDS];
    logic [31:0] mem [NUM_SLAVES][MEM_WORDS];
    int          stall_cnt [NUM_SLAVES];
    int          rr_ptr [NUM_SLAVES];
    // Trace lines waiting per master, consumed from q_head up to q_tail
    int          line_q [NUM_MASTERS][MAX_LINES];
    int          q_head [NUM_MASTERS];
    int          q_tail [NUM_MASTERS];
    logic [NUM_MASTERS-1:0] rsp_due;
    logic [NUM_MASTERS-1:0] rsp_opc;
    logic [NUM_MASTERS-1:0] rsp_chk;
    logic [31:0] rsp_data [NUM_MASTERS];
    logic [31:0] lfsr;
    int          num_lines;
    int          checks;
    int          errors;
    int          timeouts;
    int          arb_fails [NUM_SLAVES];

    tb_clock_gen clock_gen_i (.clk_o(clk_i));

    soc_interconnect soc_interconnect_i (
        .clk_i,
        .rst_n_i,
        .master_req_i  (master_req),
        .master_rsp_o  (master_rsp),
        .slave_req_o   (slave_req),
        .slave_gnt_i   (slave_gnt),
        .slave_rdata_i (slave_rdata)
    );

    for (genvar s = 0; s < NUM_SLAVES; s++) begin : gen_slave
        // A slave accepts at once unless it is stalling
        assign slave_gnt[s] = slave_req[s].req && (stall_cnt[s] == 0);
        assign arb_fails[s] = soc_interconnect_i.gen_arbiter[s].arbiter_i.arb_checks_i.fail_count;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Slave memory models, rdata is presented in the cycle after gnt
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin
        for (int s = 0; s < NUM_SLAVES; s++) begin
            if (slave_req[s].req && slave_gnt[s]) begin
                if (slave_req[s].we) begin
                    mem[s][slave_req[s].addr[9:2]] <= slave_req[s].wdata;
                end else begin
                    slave_rdata[s] <= mem[s][slave_req[s].addr[9:2]];
                end
            end
        end
    end

    function automatic logic [31:0] field(input int line, input int col);
        return trace_mem[line*FIELDS+col];
    endfunction

    // Slave port an address reaches, or -1 for the error responder
    function automatic int port_of(input logic [31:0] addr, output logic [31:0] local_addr);
        logic [31:0] offs;
        local_addr = '0;
        if (addr[31:16] == INTLV_BASE[31:16]) begin
            offs = addr - INTLV_BASE;
            // Word bits 3:2 pick the bank and are dropped from the bank address
            local_addr = ((offs >> 4) << 2) | (offs & 32'h3);
            return int'(offs[3:2]);
        end
        offs = addr - CONTIG_BASE;
        if (addr >= CONTIG_BASE && offs < NUM_CONTIG * CONTIG_SIZE) begin
            local_addr = offs % CONTIG_SIZE;
            return NUM_BANKS + int'(offs / CONTIG_SIZE);
        end
        return -1;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Stall length of 1 to 8 cycles, one LFSR step per bit
    task automatic draw_stall(output int n);
        n = 0;
        repeat (3) begin
            lfsr = lfsr_next(lfsr);
            n = (n << 1) | lfsr[0];
        end
        n = n + 1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Per-cycle drive and check
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_heads();
        int e;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            master_req[m] = '0;
            if (q_head[m] < q_tail[m]) begin
                e = line_q[m][q_head[m]];
                master_req[m].req   = 1'b1;
                master_req[m].addr  = field(e, 3);
                master_req[m].we    = field(e, 2) != 0;
                master_req[m].be    = '1;
                master_req[m].wdata = field(e, 4);
            end
        end
    endtask

    task automatic check_cycle();
        int          port [NUM_MASTERS];
        logic [31:0] laddr [NUM_MASTERS];
        logic [NUM_MASTERS-1:0] busy;
        logic [NUM_MASTERS-1:0] win;
        logic [NUM_SLAVES-1:0]  exp_sreq;
        logic        exp_gnt;
        int          cand;
        int          e;
        bit          taken;
        // Responses owed for the grants of the previous cycle
        for (int m = 0; m < NUM_MASTERS; m++) begin
            check_value($sformatf("master_rsp_o[%0d].r_valid", m), master_rsp[m].r_valid,
                        rsp_due[m]);
            if (rsp_due[m]) begin
                check_value($sformatf("master_rsp_o[%0d].r_opc", m), master_rsp[m].r_opc,
                            rsp_opc[m]);
                if (rsp_chk[m]) begin
                    check_value($sformatf("master_rsp_o[%0d].r_rdata", m),
                                master_rsp[m].r_rdata, rsp_data[m]);
                end
            end
        end
        exp_sreq = '0;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            busy[m] = q_head[m] < q_tail[m];
            port[m] = -1;
            laddr[m] = '0;
            if (busy[m]) begin
                port[m] = port_of(field(line_q[m][q_head[m]], 3), laddr[m]);
                if (port[m] >= 0) exp_sreq[port[m]] = 1'b1;
            end
        end
        // First busy master at or after the port's pointer owns the port this cycle
        win = '0;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            taken = 1'b0;
            for (int k = 0; k < NUM_MASTERS; k++) begin
                cand = (rr_ptr[port[m] < 0 ? 0 : port[m]] + k) % NUM_MASTERS;
                if (!taken && busy[m] && port[m] >= 0 && busy[cand] && port[cand] == port[m]) begin
                    taken  = 1'b1;
                    win[m] = cand == m;
                end
            end
        end
        for (int s = 0; s < NUM_SLAVES; s++) begin
            check_value($sformatf("slave_req_o[%0d].req", s), slave_req[s].req, exp_sreq[s]);
        end
        for (int m = 0; m < NUM_MASTERS; m++) begin
            if (win[m]) begin
                check_value($sformatf("slave_req_o[%0d].addr", port[m]),
                            slave_req[port[m]].addr, laddr[m]);
                check_value($sformatf("slave_req_o[%0d].we", port[m]),
                            slave_req[port[m]].we, master_req[m].we);
                check_value($sformatf("slave_req_o[%0d].be", port[m]),
                            slave_req[port[m]].be, master_req[m].be);
                check_value($sformatf("slave_req_o[%0d].wdata", port[m]),
                            slave_req[port[m]].wdata, master_req[m].wdata);
            end
            exp_gnt = busy[m] && (port[m] < 0 || (win[m] && stall_cnt[port[m]] == 0));
            check_value($sformatf("master_rsp_o[%0d].gnt", m), master_rsp[m].gnt, exp_gnt);
            rsp_due[m] = exp_gnt;
            if (exp_gnt) begin
                e = line_q[m][q_head[m]];
                rsp_opc[m]  = field(e, 6) != 0;
                rsp_data[m] = field(e, 5);
                rsp_chk[m]  = field(e, 2) == 0 || field(e, 6) != 0;
                q_head[m]++;
                // Priority passes to the master after the one just granted
                if (port[m] >= 0) rr_ptr[port[m]] = (m + 1) % NUM_MASTERS;
            end
        end
    endtask

    // Runs all adjacent trace lines that share the group of the line at hand
    task automatic run_group(inout int line);
        logic [31:0] group;
        logic [31:0] laddr;
        int          cycles;
        int          m;
        int          p;
        group = field(line, 0);
        @(posedge clk_i);
        #1;
        for (int i = 0; i < NUM_MASTERS; i++) begin
            q_head[i] = 0;
            q_tail[i] = 0;
        end
        while (line < num_lines && field(line, 0) == group) begin
            m = int'(field(line, 1));
            line_q[m][q_tail[m]] = line;
            q_tail[m]++;
            p = port_of(field(line, 3), laddr);
            if (field(line, 7) != 0 && p >= 0) draw_stall(stall_cnt[p]);
            line++;
        end
        cycles = 0;
        while ((q_head[0] < q_tail[0] || q_head[1] < q_tail[1] || rsp_due != 0)
               && cycles < GROUP_TIMEOUT) begin
            if (cycles > 0) begin
                @(posedge clk_i);
                #1;
                for (int s = 0; s < NUM_SLAVES; s++) begin
                    if (stall_cnt[s] > 0) stall_cnt[s]--;
                end
            end
            drive_heads();
            @(negedge clk_i);
            check_cycle();
            cycles++;
        end
        if (cycles >= GROUP_TIMEOUT) begin
            timeouts++;
            $display("Timeout: trace group %0h did not finish within %0d cycles", group, cycles);
            q_head = q_tail;
            rsp_due = '0;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int line;
        int assert_fails;
        rst_n_i = 1'b0;
        master_req = '0;
        lfsr = LFSR_SEED;
        checks = 0;
        errors = 0;
        timeouts = 0;
        rsp_due = '0;
        for (int s = 0; s < NUM_SLAVES; s++) begin
            stall_cnt[s] = 0;
            rr_ptr[s] = 0;
            // Fill pattern carries the port and the full word index
            for (int w = 0; w < MEM_WORDS; w++) mem[s][w] = {8'h5A, 8'(s), 8'(w), ~8'(w)};
        end
        for (int i = 0; i < MAX_LINES * FIELDS; i++) trace_mem[i] = '1;
        $readmemh("soc_interconnect_trace.txt", trace_mem);
        num_lines = 0;
        while (num_lines < MAX_LINES && trace_mem[num_lines*FIELDS] !== 32'hFFFF_FFFF) begin
            num_lines++;
        end
        if (num_lines == 0) begin
            errors++;
            $display("The trace file could not be read or held no lines");
        end
        // Reset lasts 8 rising edges and every output must stay quiet
        for (int c = 0; c <= 8; c++) begin
            @(negedge clk_i);
            for (int m = 0; m < NUM_MASTERS; m++) begin
                check_value($sformatf("master_rsp_o[%0d].gnt", m), master_rsp[m].gnt, 1'b0);
                check_value($sformatf("master_rsp_o[%0d].r_valid", m), master_rsp[m].r_valid, 1'b0);
            end
            for (int s = 0; s < NUM_SLAVES; s++) begin
                check_value($sformatf("slave_req_o[%0d].req", s), slave_req[s].req, 1'b0);
            end
            if (c == 6) begin
                @(posedge clk_i);
                #1;
                rst_n_i = 1'b1;
            end
        end
        line = 0;
        while (line < num_lines) run_group(line);
        assert_fails = soc_interconnect_i.router_i.rsp_checks_i.fail_count;
        for (int s = 0; s < NUM_SLAVES; s++) assert_fails += arb_fails[s];
        $display("Checks: %0d, value errors: %0d, timeouts: %0d, assertion failures: %0d",
                 checks, errors, timeouts, assert_fails);
        if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== soc_interconnect_trace.txt ====
// Columns in hex: group master we addr wdata exp_rdata exp_opc stall
// Adjacent lines with one group start together, a master's lines in a group run back to back
0 0 1 1C000000 A0000000 0 0 0
0 0 1 1C000004 A0000001 0 0 0
0 0 1 1C000008 A0000002 0 0 0
0 0 1 1C00000C A0000003 0 0 0
1 0 0 1C000000 0 A0000000 0 0
1 0 0 1C000004 0 A0000001 0 0
1 0 0 1C000008 0 A0000002 0 0
1 0 0 1C00000C 0 A0000003 0 0
2 1 1 1A001020 C0DE0005 0 0 0
2 0 1 1A000040 C0DE0004 0 0 0
3 1 0 1A001020 0 C0DE0005 0 0
3 0 0 1A000040 0 C0DE0004 0 0
4 0 0 30000000 0 BADACCE5 1 0
5 1 1 1A002000 12345678 BADACCE5 1 0
6 0 1 1C000010 B0000000 0 0 0
6 0 1 1C000040 B0000001 0 0 0
6 1 1 1C000020 B0000010 0 0 0
6 1 1 1C000030 B0000011 0 0 0
7 0 0 1C000010 0 B0000000 0 0
7 0 0 1C000040 0 B0000001 0 0
7 1 0 1C000020 0 B0000010 0 0
7 1 0 1C000030 0 B0000011 0 0
8 0 0 1C000004 0 A0000001 0 1
8 0 0 1C000008 0 A0000002 0 0
8 0 0 1C00000C 0 A0000003 0 0
8 1 0 1A001020 0 C0DE0005 0 0
9 0 0 00000100 0 BADACCE5 1 0
9 1 0 1C000000 0 A0000000 0 0

// ==== soc_interconnect.f ====
soc_interconnect_pkg.sv
tcdm_addr_decoder.sv
tcdm_bank_arbiter.sv
tcdm_response_router.sv
soc_interconnect.sv
tb_clock_gen.sv
soc_interconnect_assertions.sv
tb_soc_interconnect.sv
